// ==== vlog.f ====
logic/procPkg.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/result.sv
logic/proc.sv
sim/proc_assertions.sv
sim/procTb.sv

// ==== run.sh ====
#!/bin/bash
# Verilator build and run of procTb, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module procTb -o procSim \
   > build.log 2>&1 \
   && ./obj_dir/procSim > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -qx "PASS: all tests" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// ==== sim/procTb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the single-cycle processor: program table
// loaded and run per entry, trace counted until halt
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module procTb;

   localparam int nTests = 7;
   localparam int progLen = 8;
   localparam int haltTimeout = 200;

   logic clk = 1'b0;
   logic reset;
   logic loadEn;
   logic [5:0] loadAddr;
   logic [15:0] loadInstr;
   logic start;
   procPkg::wbTraceT wbTrace;
   logic halted;
   logic err;

   // Stimulus and expected results, one row per test
   string testName [nTests];
   logic [15:0] prog [nTests][progLen];
   procPkg::wbTraceT expTrace [nTests];
   int expCount [nTests];
   logic expErr [nTests];

   logic [31:0] lcgState;
   int errors = 0;
   int failedTests = 0;
   int idx;
   logic timedOut = 1'b0;

   proc u_proc (
      .clk(clk), .reset(reset), .loadEn(loadEn), .loadAddr(loadAddr),
      .loadInstr(loadInstr), .start(start), .wbTrace(wbTrace),
      .halted(halted), .err(err)
   );

   // 40 ns period
   always #20 clk = ~clk;

   // LCG step with bits 23:16 kept as an LBI immediate
   function automatic logic [7:0] nextRand();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState[23:16];
   endfunction

   // Instruction encoders
   function automatic logic [15:0] aluInstr(procPkg::aluFnT fn, logic [2:0] rd,
                                            logic [2:0] rs, logic [2:0] rt);
      return {procPkg::opAlu, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] imm5Instr(procPkg::opcodeT op, logic [2:0] rs,
                                             logic [2:0] rt, logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [15:0] imm8Instr(procPkg::opcodeT op, logic [2:0] rs,
                                             logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic logic [15:0] imm11Instr(procPkg::opcodeT op, logic [10:0] imm);
      return {op, imm};
   endfunction

   // Sign extension rules
   function automatic logic [15:0] sext5(logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   function automatic logic [15:0] sext8(logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   function automatic procPkg::wbTraceT traceOf(logic [2:0] r, logic [15:0] d);
      procPkg::wbTraceT t;
      t.valid = 1'b1;
      t.regAddr = r;
      t.data = d;
      return t;
   endfunction

   task automatic buildTable();
      logic [7:0] a8;
      logic [7:0] b8;
      logic [15:0] sum;
      logic [15:0] diff;
      logic [15:0] andv;
      for (int t = 0; t < nTests; t++) begin
         for (int w = 0; w < progLen; w++) begin
            prog[t][w] = {procPkg::opHalt, 11'b0};
         end
         expErr[t] = 1'b0;
      end
      // Random operands chained so every ALU op reaches the last result
      a8 = nextRand();
      b8 = nextRand();
      sum = sext8(a8) + sext8(b8);
      diff = sum - sext8(b8);
      andv = diff & sum;
      testName[0] = "aluOps";
      prog[0][0] = imm8Instr(procPkg::opLbi, 3'd1, a8);
      prog[0][1] = imm8Instr(procPkg::opLbi, 3'd2, b8);
      prog[0][2] = aluInstr(procPkg::fnAdd, 3'd3, 3'd1, 3'd2);
      prog[0][3] = aluInstr(procPkg::fnSub, 3'd4, 3'd3, 3'd2);
      prog[0][4] = aluInstr(procPkg::fnAnd, 3'd5, 3'd4, 3'd3);
      prog[0][5] = aluInstr(procPkg::fnXor, 3'd6, 3'd5, 3'd2);
      expTrace[0] = traceOf(3'd6, andv ^ sext8(b8));
      expCount[0] = 6;
      // Negative immediates
      testName[1] = "signExtend";
      prog[1][0] = imm8Instr(procPkg::opLbi, 3'd1, 8'h80);
      prog[1][1] = imm5Instr(procPkg::opAddi, 3'd1, 3'd2, 5'h1d);
      prog[1][2] = imm8Instr(procPkg::opLbi, 3'd3, 8'hf0);
      prog[1][3] = imm5Instr(procPkg::opAddi, 3'd3, 3'd4, 5'h10);
      expTrace[1] = traceOf(3'd4, sext8(8'hf0) + sext5(5'h10));
      expCount[1] = 4;
      // Store then load at base 5 plus 2
      testName[2] = "storeLoad";
      prog[2][0] = imm8Instr(procPkg::opLbi, 3'd1, 8'h05);
      prog[2][1] = imm8Instr(procPkg::opLbi, 3'd2, 8'ha5);
      prog[2][2] = imm5Instr(procPkg::opSt, 3'd1, 3'd2, 5'd2);
      prog[2][3] = imm5Instr(procPkg::opLd, 3'd1, 3'd3, 5'd2);
      expTrace[2] = traceOf(3'd3, sext8(8'ha5));
      expCount[2] = 3;
      // Both branches taken so the markers are skipped
      testName[3] = "branchTaken";
      prog[3][0] = imm8Instr(procPkg::opLbi, 3'd1, 8'h00);
      prog[3][1] = imm8Instr(procPkg::opBeqz, 3'd1, 8'd1);
      prog[3][2] = imm5Instr(procPkg::opAddi, 3'd1, 3'd5, 5'd1);
      prog[3][3] = imm8Instr(procPkg::opLbi, 3'd2, 8'h03);
      prog[3][4] = imm8Instr(procPkg::opBnez, 3'd2, 8'd1);
      prog[3][5] = imm5Instr(procPkg::opAddi, 3'd5, 3'd5, 5'd1);
      expTrace[3] = traceOf(3'd2, 16'h0003);
      expCount[3] = 2;
      // Neither branch taken so both markers run
      testName[4] = "branchNotTaken";
      prog[4][0] = imm8Instr(procPkg::opLbi, 3'd1, 8'h00);
      prog[4][1] = imm8Instr(procPkg::opBnez, 3'd1, 8'd1);
      prog[4][2] = imm5Instr(procPkg::opAddi, 3'd1, 3'd5, 5'd1);
      prog[4][3] = imm8Instr(procPkg::opBeqz, 3'd5, 8'd1);
      prog[4][4] = imm5Instr(procPkg::opAddi, 3'd5, 3'd6, 5'd1);
      expTrace[4] = traceOf(3'd6, 16'h0002);
      expCount[4] = 3;
      // Undefined opcode stops before the ADDI
      testName[5] = "badOpcode";
      prog[5][0] = imm8Instr(procPkg::opLbi, 3'd1, 8'h07);
      prog[5][1] = {5'b11111, 11'b0};
      prog[5][2] = imm5Instr(procPkg::opAddi, 3'd1, 3'd2, 5'd1);
      expTrace[5] = traceOf(3'd1, 16'h0007);
      expCount[5] = 1;
      expErr[5] = 1'b1;
      // JAL links pc plus one into r7 and J skips word 4
      testName[6] = "jumpLink";
      prog[6][0] = imm11Instr(procPkg::opJal, 11'd2);
      prog[6][1] = imm8Instr(procPkg::opLbi, 3'd1, 8'h01);
      prog[6][2] = imm8Instr(procPkg::opLbi, 3'd1, 8'h02);
      prog[6][3] = imm11Instr(procPkg::opJ, 11'd1);
      prog[6][4] = imm8Instr(procPkg::opLbi, 3'd2, 8'h09);
      prog[6][5] = imm5Instr(procPkg::opAddi, 3'd7, 3'd3, 5'd1);
      expTrace[6] = traceOf(3'd3, 16'h0002);
      expCount[6] = 2;
   endtask

   task automatic checkTrace(string name, procPkg::wbTraceT exp, procPkg::wbTraceT act);
      if (act !== exp) begin
         $display("Fail %s: last trace expected v%0b r%0d %h, actual v%0b r%0d %h", name,
                  exp.valid, exp.regAddr, exp.data, act.valid, act.regAddr, act.data);
         errors++;
      end
   endtask

   task automatic checkCount(string name, int exp, int act);
      if (act != exp) begin
         $display("Fail %s: trace count expected %0d, actual %0d", name, exp, act);
         errors++;
      end
   endtask

   task automatic checkErr(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("Fail %s: err expected %0b, actual %0b", name, exp, act);
         errors++;
      end
   endtask

   // Load one program, start it and collect traces until halted
   task automatic runTest(int t);
      int cycles;
      int count;
      int errBefore;
      logic done;
      procPkg::wbTraceT lastTrace;
      errBefore = errors;
      count = 0;
      cycles = 0;
      done = 1'b0;
      lastTrace = '0;
      for (int a = 0; a < progLen; a++) begin
         @(posedge clk);
         loadEn <= 1'b1;
         loadAddr <= 6'(a);
         loadInstr <= prog[t][a];
      end
      @(posedge clk);
      loadEn <= 1'b0;
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      // Sample mid-cycle where the trace is settled
      while (!done && cycles < haltTimeout) begin
         @(negedge clk);
         if (wbTrace.valid) begin
            count++;
            lastTrace = wbTrace;
         end
         done = halted;
         cycles++;
      end
      if (!done) begin
         $display("Test %s: halted never rose within %0d cycles", testName[t], haltTimeout);
         errors++;
         timedOut = 1'b1;
      end else begin
         checkTrace(testName[t], expTrace[t], lastTrace);
         checkCount(testName[t], expCount[t], count);
         checkErr(testName[t], expErr[t], err);
      end
      if (errors != errBefore) begin
         failedTests++;
         $display("Test %s failed", testName[t]);
      end else begin
         $display("Test %s passed", testName[t]);
      end
   endtask

   initial begin
      reset <= 1'b1;
      loadEn <= 1'b0;
      loadAddr <= '0;
      loadInstr <= '0;
      start <= 1'b0;
      lcgState = 32'd99;
      buildTable();
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      idx = 0;
      while (idx < nTests && !timedOut) begin
         runTest(idx);
         idx++;
      end
      $display("Tests run %0d, failed %0d, check errors %0d", idx, failedTests, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// ==== sim/proc_assertions.sv ====
////////////////////////////////////////////////////////////
// Bound checks on run state, write-back trace and pc hold
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module proc_assertions (
   input logic        clk,
   input logic        reset,
   input logic        start,
   input logic        running,
   input logic        halted,
   input logic [15:0] pc,
   input logic        wbValid
);

   // A register write is only traced while an instruction runs
   traceInRun: assert property (@(posedge clk) disable iff (reset) wbValid |-> running)
      else $error("Write-back trace valid while the machine is not running");

   // Run and halt states exclude each other
   runHaltExclusive: assert property (@(posedge clk) disable iff (reset) !(halted && running))
      else $error("Halted and running are high together");

   // Frozen pc until the next start
   pcHoldsHalted: assert property (@(posedge clk) disable iff (reset)
      (halted && !start) |=> (pc == $past(pc)))
      else $error("Program counter moved while halted");

endmodule

// Top level holds the trace, the fetch state and the start strobe
bind proc proc_assertions procChecks (
   .clk(clk), .reset(reset), .start(start), .running(running),
   .halted(halted), .pc(pc), .wbValid(wbTrace.valid)
);

// ==== logic/proc.sv ====
////////////////////////////////////////////////////////////
// Single-cycle 16-bit processor top level
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module proc (
   input  logic             clk,
   input  logic             reset,
   input  logic             loadEn,
   input  logic [5:0]       loadAddr,
   input  logic [15:0]      loadInstr,
   input  logic             start,
   output procPkg::wbTraceT wbTrace,
   output logic             halted,
   output logic             err
);

   logic [15:0] instr;
   logic [15:0] pc;
   logic [15:0] incPc;
   logic [15:0] nextPc;
   logic [15:0] aluOut;
   logic [15:0] wbData;
   logic running;
   logic halt;
   logic decodeErr;
   procPkg::ctrlT ctrl;
   procPkg::operandT operands;

   // Stop on HALT or on a bad opcode
   assign halt = ctrl.halt | decodeErr;

   fetch fetchStage (
      .clk(clk), .reset(reset),
      .loadEn(loadEn), .loadAddr(loadAddr), .loadInstr(loadInstr),
      .start(start), .halt(halt), .nextPc(nextPc),
      .instr(instr), .pc(pc), .incPc(incPc),
      .running(running), .halted(halted)
   );

   // Write-back port fed from the trace
   decode decodeStage (
      .clk(clk), .reset(reset), .instr(instr), .running(running),
      .wbReg(wbTrace.regAddr), .wbWrite(wbTrace.valid), .wbData(wbData),
      .ctrl(ctrl), .operands(operands), .decodeErr(decodeErr)
   );

   execute executeStage (
      .ctrl(ctrl), .operands(operands), .pc(pc), .incPc(incPc),
      .aluOut(aluOut), .nextPc(nextPc)
   );

   result resultStage (
      .clk(clk), .reset(reset), .ctrl(ctrl), .aluOut(aluOut),
      .storeData(operands.read2Data), .incPc(incPc), .running(running),
      .wbData(wbData), .wbTrace(wbTrace)
   );

   // Sticky error, cleared by the next start
   always_ff @(posedge clk) begin
      if (reset || start) begin
         err <= 1'b0;
      end else if (decodeErr) begin
         err <= 1'b1;
      end
   end

endmodule

// ==== logic/result.sv ====
////////////////////////////////////////////////////////////
// Result: data memory, write-back select and trace
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module result (
   input  logic             clk,
   input  logic             reset,
   input  procPkg::ctrlT    ctrl,
   input  logic [15:0]      aluOut,
   input  logic [15:0]      storeData,
   input  logic [15:0]      incPc,
   input  logic             running,
   output logic [15:0]      wbData,
   output procPkg::wbTraceT wbTrace
);

   logic [procPkg::dataW-1:0] dmem [procPkg::dmemDepth];
   logic [procPkg::dmemAddrW-1:0] memAddr;
   logic [procPkg::dataW-1:0] memData;

   // Word address from the low bits of the ALU sum
   assign memAddr = aluOut[procPkg::dmemAddrW-1:0];

   // Store commits on the same edge as the pc update
   always_ff @(posedge clk) begin
      if (!reset && running && ctrl.memWrite) begin
         dmem[memAddr] <= storeData;
      end
   end

   // Asynchronous read, only for loads
   assign memData = ctrl.memRead ? dmem[memAddr] : '0;

   // Write-back select
   always_comb begin
      if (ctrl.memToReg) begin
         wbData = memData;
      end else if (ctrl.link) begin
         // JAL saves the return address
         wbData = incPc;
      end else begin
         wbData = aluOut;
      end
   end

   // Trace doubles as the register file write port
   assign wbTrace.valid = running & ctrl.regWrite;
   assign wbTrace.regAddr = ctrl.link ? procPkg::linkReg : ctrl.writeReg;
   assign wbTrace.data = wbData;

endmodule

// ==== logic/execute.sv ====
////////////////////////////////////////////////////////////
// Execute: ALU, branch test and next-PC select
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module execute (
   input  procPkg::ctrlT    ctrl,
   input  procPkg::operandT operands,
   input  logic [15:0]      pc,
   input  logic [15:0]      incPc,
   output logic [15:0]      aluOut,
   output logic [15:0]      nextPc
);

   // ALU operands
   logic [procPkg::dataW-1:0] aluA;
   logic [procPkg::dataW-1:0] aluB;
   // Branch and jump target
   logic [procPkg::dataW-1:0] targetPc;
   logic isZero;
   logic takeBranch;

   // A side is always Rs
   assign aluA = operands.read1Data;

   // B side is Rt or the extended immediate
   assign aluB = ctrl.aluSrcImm ? operands.immVal : operands.read2Data;

   // ALU
   // SUB is Rs minus B
   // Pass B serves LBI
   always_comb begin
      case (ctrl.aluOp)
         procPkg::aluAdd: begin
            aluOut = aluA + aluB;
         end
         procPkg::aluSub: begin
            aluOut = aluA - aluB;
         end
         procPkg::aluAnd: begin
            aluOut = aluA & aluB;
         end
         procPkg::aluXor: begin
            aluOut = aluA ^ aluB;
         end
         procPkg::aluPassB: begin
            aluOut = aluB;
         end
         default: begin
            aluOut = '0;
         end
      endcase
   end

   // Branch condition on Rs
   assign isZero = (operands.read1Data == '0);

   // Taken for a passing conditional branch or any jump
   always_comb begin
      takeBranch = 1'b0;
      if (ctrl.jump) begin
         takeBranch = 1'b1;
      end else if (ctrl.branchZero && isZero) begin
         takeBranch = 1'b1;
      end else if (ctrl.branchNonZero && !isZero) begin
         takeBranch = 1'b1;
      end
   end

   // Displacement is relative to pc plus one
   assign targetPc = incPc + operands.immVal;

   // Next pc
   // HALT holds the current pc
   always_comb begin
      if (ctrl.halt) begin
         nextPc = pc;
      end else if (takeBranch) begin
         nextPc = targetPc;
      end else begin
         nextPc = incPc;
      end
   end

endmodule

// ==== logic/decode.sv ====
////////////////////////////////////////////////////////////
// Decode: control decoder, register file, immediate extend
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module decode (
   input  logic              clk,
   input  logic              reset,
   input  logic [15:0]       instr,
   input  logic              running,
   input  logic [2:0]        wbReg,
   input  logic              wbWrite,
   input  logic [15:0]       wbData,
   output procPkg::ctrlT     ctrl,
   output procPkg::operandT  operands,
   output logic              decodeErr
);

   procPkg::opcodeT opcode;
   procPkg::aluFnT  fn;
   // Rs always read port 1, Rt read port 2 (also ST data)
   logic [procPkg::regAddrW-1:0] rs;
   logic [procPkg::regAddrW-1:0] rt;
   logic [procPkg::regAddrW-1:0] rd;
   logic [procPkg::dataW-1:0] imm5Ext;
   logic [procPkg::dataW-1:0] imm8Ext;
   logic [procPkg::dataW-1:0] imm11Ext;
   logic [procPkg::dataW-1:0] immVal;
   logic illegal;
   logic [procPkg::dataW-1:0] regFile [8];

   // Field split
   assign opcode = procPkg::opcodeT'(instr[15:11]);
   assign rs = instr[10:8];
   assign rt = instr[7:5];
   assign rd = instr[4:2];
   assign fn = procPkg::aluFnT'(instr[1:0]);

   // Sign extension of the three immediate sizes
   assign imm5Ext = {{11{instr[4]}}, instr[4:0]};
   assign imm8Ext = {{8{instr[7]}}, instr[7:0]};
   assign imm11Ext = {{5{instr[10]}}, instr[10:0]};

   // Control decoder
   always_comb begin
      ctrl = '0;
      immVal = '0;
      illegal = 1'b0;
      case (opcode)
         procPkg::opAlu: begin
            ctrl.regWrite = 1'b1;
            ctrl.writeReg = rd;
            case (fn)
               procPkg::fnAdd: ctrl.aluOp = procPkg::aluAdd;
               procPkg::fnSub: ctrl.aluOp = procPkg::aluSub;
               procPkg::fnAnd: ctrl.aluOp = procPkg::aluAnd;
               procPkg::fnXor: ctrl.aluOp = procPkg::aluXor;
            endcase
         end
         procPkg::opAddi: begin
            ctrl.regWrite = 1'b1;
            ctrl.writeReg = rt;
            ctrl.aluSrcImm = 1'b1;
            immVal = imm5Ext;
         end
         procPkg::opLbi: begin
            // LBI writes back into its Rs field
            ctrl.regWrite = 1'b1;
            ctrl.writeReg = rs;
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp = procPkg::aluPassB;
            immVal = imm8Ext;
         end
         procPkg::opLd: begin
            ctrl.regWrite = 1'b1;
            ctrl.writeReg = rt;
            ctrl.aluSrcImm = 1'b1;
            ctrl.memRead = 1'b1;
            ctrl.memToReg = 1'b1;
            immVal = imm5Ext;
         end
         procPkg::opSt: begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.memWrite = 1'b1;
            immVal = imm5Ext;
         end
         procPkg::opBeqz: begin
            ctrl.branchZero = 1'b1;
            immVal = imm8Ext;
         end
         procPkg::opBnez: begin
            ctrl.branchNonZero = 1'b1;
            immVal = imm8Ext;
         end
         procPkg::opJ: begin
            ctrl.jump = 1'b1;
            immVal = imm11Ext;
         end
         procPkg::opJal: begin
            // Link target register picked in result
            ctrl.jump = 1'b1;
            ctrl.link = 1'b1;
            ctrl.regWrite = 1'b1;
            immVal = imm11Ext;
         end
         procPkg::opNop: begin
         end
         procPkg::opHalt: ctrl.halt = 1'b1;
         // Unknown opcode behaves as NOP plus error
         default: illegal = 1'b1;
      endcase
   end

   assign decodeErr = running & illegal;

   // Register file, write on the commit edge
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            regFile[i] <= '0;
         end
      end else if (wbWrite) begin
         regFile[wbReg] <= wbData;
      end
   end

   assign operands.read1Data = regFile[rs];
   assign operands.read2Data = regFile[rt];
   assign operands.immVal = immVal;

endmodule

// ==== logic/fetch.sv ====
////////////////////////////////////////////////////////////
// Fetch: run/halt FSM, program counter, loadable imem
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module fetch (
   input  logic        clk,
   input  logic        reset,
   input  logic        loadEn,
   input  logic [5:0]  loadAddr,
   input  logic [15:0] loadInstr,
   input  logic        start,
   input  logic        halt,
   input  logic [15:0] nextPc,
   output logic [15:0] instr,
   output logic [15:0] pc,
   output logic [15:0] incPc,
   output logic        running,
   output logic        halted
);

   procPkg::runStateT state;
   logic [procPkg::dataW-1:0] imem [procPkg::imemDepth];

   // Run state and pc
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= procPkg::stIdle;
         pc <= '0;
      end else if (state == procPkg::stRun) begin
         // Halt freezes pc on the halting edge
         if (halt) begin
            state <= procPkg::stHalted;
         end else begin
            pc <= nextPc;
         end
      end else if (start) begin
         // Start from idle or halted restarts at address 0
         state <= procPkg::stRun;
         pc <= '0;
      end
   end

   // Program load port, locked out while running
   always_ff @(posedge clk) begin
      if (loadEn && !running) begin
         imem[loadAddr] <= loadInstr;
      end
   end

   assign running = (state == procPkg::stRun);
   assign halted = (state == procPkg::stHalted);
   assign incPc = pc + 16'd1;
   // NOP outside stRun so nothing downstream changes state
   assign instr = running ? imem[pc[procPkg::imemAddrW-1:0]] : procPkg::nopInstr;

endmodule

// ==== logic/procPkg.sv ====
////////////////////////////////////////////////////////////
// Processor package: opcodes, field widths and the structs
// passed between the fetch, decode, execute and result stages
////////////////////////////////////////////////////////////
package procPkg;

   // Data and instruction word width
   localparam int dataW = 16;
   // Register index and instruction field widths
   localparam int regAddrW = 3;
   localparam int opW = 5;
   localparam int fnW = 2;

   // Memory sizes in words
   localparam int imemDepth = 64;
   localparam int dmemDepth = 64;
   localparam int imemAddrW = $clog2(imemDepth);
   localparam int dmemAddrW = $clog2(dmemDepth);

   // JAL always links into r7
   localparam logic [regAddrW-1:0] linkReg = 3'd7;

   // Major opcode, instr[15:11]
   typedef enum logic [opW-1:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opJ    = 5'b00100,
      opJal  = 5'b00110,
      opAddi = 5'b01000,
      opBeqz = 5'b01100,
      opBnez = 5'b01101,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opLbi  = 5'b11000,
      opAlu  = 5'b11011
   } opcodeT;

   // Function field of register ops, instr[1:0]
   typedef enum logic [fnW-1:0] {
      fnAdd = 2'b00,
      fnSub = 2'b01,
      fnAnd = 2'b10,
      fnXor = 2'b11
   } aluFnT;

   // Operation handed from decode to the ALU
   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluXor,
      aluPassB
   } aluOpT;

   // Fetch run state
   typedef enum logic [1:0] {
      stIdle,
      stRun,
      stHalted
   } runStateT;

   // Encoded NOP, fed to decode whenever the machine is not running
   localparam logic [dataW-1:0] nopInstr = {opNop, 11'b0};

   // Control bundle built by decode
   typedef struct packed {
      aluOpT               aluOp;
      logic                aluSrcImm;
      logic                regWrite;
      logic [regAddrW-1:0] writeReg;
      logic                memRead;
      logic                memWrite;
      logic                memToReg;
      logic                branchZero;
      logic                branchNonZero;
      logic                jump;
      logic                link;
      logic                halt;
   } ctrlT;

   // Register operands and extended immediate
   typedef struct packed {
      logic [dataW-1:0] read1Data;
      logic [dataW-1:0] read2Data;
      logic [dataW-1:0] immVal;
   } operandT;

   // One register write, valid in the cycle before it commits
   typedef struct packed {
      logic                valid;
      logic [regAddrW-1:0] regAddr;
      logic [dataW-1:0]    data;
   } wbTraceT;

endpackage
